// File: tests/fetch_stimulus.txt
# in : stall flush res_valid res_pc res_taken res_mispredict res_target res_which res_hist imem_err imem_data
# exp: fetch_addr (this cycle), after the edge: inst_addr inst_data taken pdt_res which_pdt trap
0 0 0 00000000 0 0 00000000 0 00 0 00000013 7ffffffc 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00100093 80000000 80000000 00100093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00200093 80000004 80000004 00200093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 0100006f 80000008 80000008 0100006f 1 1 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00300093 80000018 80000018 00300093 0 0 0 0
1 0 0 00000000 0 0 00000000 0 00 0 00400093 8000001c 80000018 00300093 0 0 0 0
1 0 0 00000000 0 0 00000000 0 00 0 00400093 8000001c 80000018 00300093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00400093 8000001c 8000001c 00400093 0 0 0 0
0 1 0 00000000 0 0 00000000 0 00 0 00500093 80000020 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00600093 80000024 80000024 00600093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00700093 80000028 80000028 00700093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00800093 8000002c 8000002c 00800093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 fe000ce3 80000030 80000030 fe000ce3 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00900093 80000034 80000034 00900093 0 0 0 0
1 0 1 80000030 1 1 80000028 0 00 0 00a00093 80000038 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00700093 80000028 80000028 00700093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00800093 8000002c 8000002c 00800093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 fe000ce3 80000030 80000030 fe000ce3 1 1 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00700093 80000028 80000028 00700093 0 0 0 0
0 0 1 80000030 0 1 80000034 0 01 0 00800093 8000002c 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00900093 80000034 80000034 00900093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 1 00a00093 80000038 80000038 00a00093 0 0 0 2
0 0 0 00000000 0 0 00000000 0 00 0 0060006f 8000003c 8000003c 0060006f 1 1 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00b00093 80000042 80000042 00b00093 0 0 0 1
0 0 0 00000000 0 0 00000000 0 00 1 00c00093 80000046 80000046 00c00093 0 0 0 3
0 0 1 8000003c 1 1 80000040 0 02 0 00d00093 8000004a 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00e00093 80000040 80000040 00e00093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00f00093 80000044 80000044 00f00093 0 0 0 0
1 1 0 00000000 0 0 00000000 0 00 0 01000093 80000048 00000013 00000013 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 01000093 80000048 80000048 01000093 0 0 0 0
0 0 1 80000050 1 0 00000000 0 05 0 01100093 8000004c 8000004c 01100093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00000463 80000050 80000050 00000463 1 1 0 0
0 0 0 00000000 0 0 00000000 0 00 0 01200093 80000058 80000058 01200093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 01300093 8000005c 8000005c 01300093 0 0 0 0
0 0 0 00000000 0 0 00000000 0 00 0 00000013 80000060 80000060 00000013 0 0 0 0

// File: fetch_top.f
rtl/fetch_pkg.sv
rtl/bpu_bus.sv
rtl/pc_gen.sv
rtl/branch_predictor.sv
rtl/if_id.sv
rtl/fetch_top.sv
tests/tb_fetch_top.sv

// File: Makefile
# Verilator build for the fetch front end, run from the project root.

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= fetch_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# build and run; the status comes from a search for the pass message in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top
  import fetch_pkg::*;
();

  logic                clk;
  logic                arst_n;
  logic                stall;
  logic                flush;
  logic [INST_LEN-1:0] imem_addr;
  logic [INST_LEN-1:0] imem_data;
  logic                imem_err;
  logic                res_valid;
  logic [INST_LEN-1:0] res_pc;
  logic                res_taken;
  logic                res_mispredict;
  logic [INST_LEN-1:0] res_target;
  logic                res_which_pdt;
  logic [HIS_LEN-1:0]  res_history;
  logic [INST_LEN-1:0] inst_addr;
  logic [INST_LEN-1:0] inst_data;
  logic                bpu_taken;
  logic                bpu_pdt_res;
  logic                bpu_which_pdt;
  logic [HIS_LEN-1:0]  bpu_history;
  logic [TRAP_LEN-1:0] trap;

  logic [31:0] vec_mem [64][18];  // one row per stimulus line, columns as in the file
  int          n_vec;
  logic        loaded;

  logic [HIS_LEN-1:0] hist_model;  // global history as the resolves build it
  logic [HIS_LEN-1:0] hist_exp;    // history expected at the stage output

  fetch_top i_dut (
    .clk              (clk),
    .arst_n_i         (arst_n),
    .stall_i          (stall),
    .flush_i          (flush),
    .imem_addr_o      (imem_addr),
    .imem_data_i      (imem_data),
    .imem_err_i       (imem_err),
    .res_valid_i      (res_valid),
    .res_pc_i         (res_pc),
    .res_taken_i      (res_taken),
    .res_mispredict_i (res_mispredict),
    .res_target_i     (res_target),
    .res_which_pdt_i  (res_which_pdt),
    .res_history_i    (res_history),
    .inst_addr_o      (inst_addr),
    .inst_data_o      (inst_data),
    .bpu_taken_o      (bpu_taken),
    .bpu_pdt_res_o    (bpu_pdt_res),
    .bpu_which_pdt_o  (bpu_which_pdt),
    .bpu_history_o    (bpu_history),
    .trap_o           (trap)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("an output did not match its expected value");
    end
  endtask

  // *********************************************************************
  // stimulus file
  // *********************************************************************
  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    n_vec = 0;
    fd = $fopen("tests/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("the stimulus file tests/fetch_stimulus.txt could not be opened");
    end else begin
      while (n_vec < 64 && $fgets(line, fd) > 0) begin
        if (line.getc(0) != "#") begin  // lines starting with # describe the columns
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec_mem[n_vec][0], vec_mem[n_vec][1], vec_mem[n_vec][2],
                        vec_mem[n_vec][3], vec_mem[n_vec][4], vec_mem[n_vec][5],
                        vec_mem[n_vec][6], vec_mem[n_vec][7], vec_mem[n_vec][8],
                        vec_mem[n_vec][9], vec_mem[n_vec][10], vec_mem[n_vec][11],
                        vec_mem[n_vec][12], vec_mem[n_vec][13], vec_mem[n_vec][14],
                        vec_mem[n_vec][15], vec_mem[n_vec][16], vec_mem[n_vec][17]);
          if (cnt == 18) begin
            n_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int idx);
    stall          <= vec_mem[idx][0][0];
    flush          <= vec_mem[idx][1][0];
    res_valid      <= vec_mem[idx][2][0];
    res_pc         <= vec_mem[idx][3];
    res_taken      <= vec_mem[idx][4][0];
    res_mispredict <= vec_mem[idx][5][0];
    res_target     <= vec_mem[idx][6];
    res_which_pdt  <= vec_mem[idx][7][0];
    res_history    <= vec_mem[idx][8][HIS_LEN-1:0];
    imem_err       <= vec_mem[idx][9][0];
    imem_data      <= vec_mem[idx][10];  // memory answers for the current fetch address
  endtask

  // expected history for the edge that ends this vector's cycle
  task automatic step_history_model(input int idx);
    logic clear;
    clear = vec_mem[idx][1][0] | (vec_mem[idx][2][0] & vec_mem[idx][5][0])
            | (vec_mem[idx][11] == PC_PRE_RESET);
    if (clear) begin
      hist_exp = '0;
    end else if (!vec_mem[idx][0][0]) begin
      hist_exp = hist_model;  // stage captures the history seen at fetch
    end
    if (vec_mem[idx][2][0]) begin
      hist_model = {hist_model[HIS_LEN-2:0], vec_mem[idx][4][0]};
    end
  endtask

  task automatic check_cleared();
    check_val("inst_addr_o", inst_addr, INST_NOP);
    check_val("inst_data_o", inst_data, INST_NOP);
    check_val("bpu_taken_o", 32'(bpu_taken), 32'h0);
    check_val("bpu_pdt_res_o", 32'(bpu_pdt_res), 32'h0);
    check_val("bpu_which_pdt_o", 32'(bpu_which_pdt), 32'h0);
    check_val("bpu_history_o", 32'(bpu_history), 32'h0);
    check_val("trap_o", 32'(trap), 32'h0);
  endtask

  task automatic check_outputs(input int idx);
    check_val("inst_addr_o", inst_addr, vec_mem[idx][12]);
    check_val("inst_data_o", inst_data, vec_mem[idx][13]);
    check_val("bpu_taken_o", 32'(bpu_taken), vec_mem[idx][14]);
    check_val("bpu_pdt_res_o", 32'(bpu_pdt_res), vec_mem[idx][15]);
    check_val("bpu_which_pdt_o", 32'(bpu_which_pdt), vec_mem[idx][16]);
    check_val("bpu_history_o", 32'(bpu_history), 32'(hist_exp));
    check_val("trap_o", 32'(trap), vec_mem[idx][17]);
  endtask

  // *********************************************************************
  // main sequence
  // *********************************************************************
  initial begin
    arst_n         = 1'b0;
    stall          = 1'b0;
    flush          = 1'b0;
    imem_data      = '0;
    imem_err       = 1'b0;
    res_valid      = 1'b0;
    res_pc         = '0;
    res_taken      = 1'b0;
    res_mispredict = 1'b0;
    res_target     = '0;
    res_which_pdt  = 1'b0;
    res_history    = '0;
    hist_model     = '0;
    hist_exp       = '0;
    loaded         = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_vec; i++) begin
      drive_vector(i);
      @(negedge clk);
      check_val("imem_addr_o", imem_addr, vec_mem[i][11]);
      if (i == 0) begin
        check_cleared();  // still the reset contents of the stage register
      end else begin
        check_outputs(i - 1);
      end
      step_history_model(i);
      @(posedge clk);
    end
    @(negedge clk);
    check_outputs(n_vec - 1);
    $display("Simulation PASSED");
    $finish;
  end

  // reset, every vector and some slack
  initial begin
    wait (loaded);
    #((n_vec + 8) * 20 * 2);
    abort_run("the run timed out before all vectors were checked");
  end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  logic                stall_i,
  input  logic                flush_i,
  // instruction memory, answers in the same cycle
  output logic [INST_LEN-1:0] imem_addr_o,
  input  logic [INST_LEN-1:0] imem_data_i,
  input  logic                imem_err_i,
  // resolution from a later stage
  input  logic                res_valid_i,
  input  logic [INST_LEN-1:0] res_pc_i,
  input  logic                res_taken_i,
  input  logic                res_mispredict_i,
  input  logic [INST_LEN-1:0] res_target_i,
  input  logic                res_which_pdt_i,
  input  logic [HIS_LEN-1:0]  res_history_i,
  // toward decode
  output logic [INST_LEN-1:0] inst_addr_o,
  output logic [INST_LEN-1:0] inst_data_o,
  output logic                bpu_taken_o,
  output logic                bpu_pdt_res_o,
  output logic                bpu_which_pdt_o,
  output logic [HIS_LEN-1:0]  bpu_history_o,
  output logic [TRAP_LEN-1:0] trap_o
);

  logic                redirect;
  logic                stage_clear;
  logic [INST_LEN-1:0] pc;
  logic [INST_LEN-1:0] pred_target;
  logic [TRAP_LEN-1:0] fetch_trap;

  bpu_bus u_bpu_bus ();

  assign redirect    = res_valid_i & res_mispredict_i;
  assign stage_clear = redirect | flush_i;  // wrong-path slot or external flush
  assign imem_addr_o = pc;

  always_comb begin
    fetch_trap = '0;
    fetch_trap[TRAP_ACCESS_FAULT] = imem_err_i;  // misalignment is added in the stage register
  end

  // *********************************************************************
  // fetch blocks
  // *********************************************************************
  pc_gen u_pc_gen (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .stall_i           (stall_i),
    .redirect_i        (redirect),
    .redirect_target_i (res_target_i),
    .pred_taken_i      (u_bpu_bus.taken),
    .pred_target_i     (pred_target),
    .pc_o              (pc)
  );

  branch_predictor u_branch_predictor (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .pc_i            (pc),
    .inst_i          (imem_data_i),
    .target_o        (pred_target),
    .bpu             (u_bpu_bus.pred),
    .res_valid_i     (res_valid_i),
    .res_pc_i        (res_pc_i),
    .res_taken_i     (res_taken_i),
    .res_which_pdt_i (res_which_pdt_i),
    .res_history_i   (res_history_i)
  );

  if_id u_if_id (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .stall_i         (stall_i),
    .clear_i         (stage_clear),
    .inst_addr_i     (pc),
    .inst_data_i     (imem_data_i),
    .trap_i          (fetch_trap),
    .bpu             (u_bpu_bus.stage),
    .inst_addr_o     (inst_addr_o),
    .inst_data_o     (inst_data_o),
    .trap_o          (trap_o),
    .bpu_taken_o     (bpu_taken_o),
    .bpu_pdt_res_o   (bpu_pdt_res_o),
    .bpu_which_pdt_o (bpu_which_pdt_o),
    .bpu_history_o   (bpu_history_o)
  );

endmodule

`default_nettype wire

// File: rtl/if_id.sv
`default_nettype none

module if_id
  import fetch_pkg::*;
(
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  logic                stall_i,
  input  logic                clear_i,
  input  logic [INST_LEN-1:0] inst_addr_i,
  input  logic [INST_LEN-1:0] inst_data_i,
  input  logic [TRAP_LEN-1:0] trap_i,
  bpu_bus.stage               bpu,
  output logic [INST_LEN-1:0] inst_addr_o,
  output logic [INST_LEN-1:0] inst_data_o,
  output logic [TRAP_LEN-1:0] trap_o,
  output logic                bpu_taken_o,
  output logic                bpu_pdt_res_o,
  output logic                bpu_which_pdt_o,
  output logic [HIS_LEN-1:0]  bpu_history_o
);

  logic                squash;
  logic [TRAP_LEN-1:0] trap_d;

  // the pre-reset slot is dropped just like a flushed one
  assign squash = clear_i | (inst_addr_i == PC_PRE_RESET);

  always_comb begin
    trap_d = trap_i;
    trap_d[TRAP_ADDR_MISALIGN] = trap_i[TRAP_ADDR_MISALIGN] | (inst_addr_i[1:0] != 2'b00);
  end

  // *********************************************************************
  // stage register
  // *********************************************************************
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_addr_o     <= INST_NOP;  // address slot also reads as nop
      inst_data_o     <= INST_NOP;
      trap_o          <= '0;
      bpu_taken_o     <= 1'b0;
      bpu_pdt_res_o   <= 1'b0;
      bpu_which_pdt_o <= PDT_BIMODAL;
      bpu_history_o   <= '0;
    end else if (squash) begin
      inst_addr_o     <= INST_NOP;  // clear has priority over stall
      inst_data_o     <= INST_NOP;
      trap_o          <= '0;
      bpu_taken_o     <= 1'b0;
      bpu_pdt_res_o   <= 1'b0;
      bpu_which_pdt_o <= PDT_BIMODAL;
      bpu_history_o   <= '0;
    end else if (!stall_i) begin
      inst_addr_o     <= inst_addr_i;
      inst_data_o     <= inst_data_i;
      trap_o          <= trap_d;
      bpu_taken_o     <= bpu.taken;
      bpu_pdt_res_o   <= bpu.pdt_res;
      bpu_which_pdt_o <= bpu.which_pdt;
      bpu_history_o   <= bpu.history;
    end
  end

endmodule

`default_nettype wire

// File: rtl/branch_predictor.sv
`default_nettype none

module branch_predictor
  import fetch_pkg::*;
(
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  logic [INST_LEN-1:0] pc_i,
  input  logic [INST_LEN-1:0] inst_i,
  output logic [INST_LEN-1:0] target_o,
  bpu_bus.pred                bpu,
  input  logic                res_valid_i,
  input  logic [INST_LEN-1:0] res_pc_i,
  input  logic                res_taken_i,
  input  logic                res_which_pdt_i,
  input  logic [HIS_LEN-1:0]  res_history_i
);

  logic [1:0] bim_q [PHT_SIZE];  // bimodal direction counters
  logic [1:0] gsh_q [PHT_SIZE];  // gshare direction counters
  logic [1:0] cho_q [PHT_SIZE];  // chooser, upper bit set selects gshare

  logic [HIS_LEN-1:0] hist_q;

  logic [PHT_IDX-1:0]  pc_idx;
  logic [PHT_IDX-1:0]  gsh_idx;
  logic [6:0]          opcode;
  logic                is_jal;
  logic                is_branch;
  logic [INST_LEN-1:0] j_imm;
  logic [INST_LEN-1:0] b_imm;
  logic                use_gsh;
  logic                dir;

  logic [PHT_IDX-1:0] res_idx;
  logic [PHT_IDX-1:0] res_gidx;
  logic               res_bim_dir;
  logic               res_gsh_dir;
  logic               res_used_dir;
  logic               res_disagree;
  logic               cho_up;

  function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
    logic [1:0] nxt;
    nxt = cnt;
    if (up && cnt != 2'b11) begin
      nxt = cnt + 2'b01;
    end else if (!up && cnt != 2'b00) begin
      nxt = cnt - 2'b01;
    end
    return nxt;
  endfunction

  // *********************************************************************
  // pre-decode and target
  // *********************************************************************
  assign opcode    = inst_i[6:0];
  assign is_jal    = (opcode == OPC_JAL);
  assign is_branch = (opcode == OPC_BRANCH);

  assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  assign target_o = pc_i + (is_jal ? j_imm : b_imm);

  // *********************************************************************
  // tournament lookup
  // *********************************************************************
  assign pc_idx  = pc_i[PHT_IDX+1:2];
  assign gsh_idx = pc_idx ^ PHT_IDX'(hist_q);
  assign use_gsh = cho_q[pc_idx][1];
  assign dir     = use_gsh ? gsh_q[gsh_idx][1] : bim_q[pc_idx][1];

  assign bpu.taken     = is_jal | (is_branch & dir);
  assign bpu.pdt_res   = is_branch ? dir : is_jal;  // jal always counts as taken
  assign bpu.which_pdt = (is_branch && use_gsh) ? PDT_GSHARE : PDT_BIMODAL;
  assign bpu.history   = hist_q;

  // *********************************************************************
  // training at resolve
  // *********************************************************************
  assign res_idx      = res_pc_i[PHT_IDX+1:2];
  assign res_gidx     = res_idx ^ PHT_IDX'(res_history_i);
  assign res_bim_dir  = bim_q[res_idx][1];
  assign res_gsh_dir  = gsh_q[res_gidx][1];
  assign res_used_dir = (res_which_pdt_i == PDT_GSHARE) ? res_gsh_dir : res_bim_dir;
  assign res_disagree = res_bim_dir ^ res_gsh_dir;

  // reward the predictor that was used when it was right, otherwise the other one
  assign cho_up = (res_used_dir == res_taken_i) ? (res_which_pdt_i == PDT_GSHARE)
                                                : (res_which_pdt_i == PDT_BIMODAL);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < PHT_SIZE; i++) begin
        bim_q[i] <= CNT_INIT;
        gsh_q[i] <= CNT_INIT;
        cho_q[i] <= CNT_INIT;
      end
      hist_q <= '0;
    end else if (res_valid_i) begin
      bim_q[res_idx]  <= sat_step(bim_q[res_idx], res_taken_i);
      gsh_q[res_gidx] <= sat_step(gsh_q[res_gidx], res_taken_i);
      if (res_disagree) begin
        cho_q[res_idx] <= sat_step(cho_q[res_idx], cho_up);
      end
      hist_q <= {hist_q[HIS_LEN-2:0], res_taken_i};  // history moves only at resolve
    end
  end

endmodule

`default_nettype wire

// File: rtl/pc_gen.sv
`default_nettype none

module pc_gen
  import fetch_pkg::*;
(
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  logic                stall_i,
  input  logic                redirect_i,
  input  logic [INST_LEN-1:0] redirect_target_i,
  input  logic                pred_taken_i,
  input  logic [INST_LEN-1:0] pred_target_i,
  output logic [INST_LEN-1:0] pc_o
);

  logic [INST_LEN-1:0] pc_q;
  logic [INST_LEN-1:0] pc_d;
  logic [INST_LEN-1:0] pc_seq;

  assign pc_seq = pc_q + PC_STEP;

  // *********************************************************************
  // next fetch address
  // *********************************************************************
  always_comb begin
    if (redirect_i) begin
      pc_d = redirect_target_i;  // resolved mispredict wins even over stall
    end else if (stall_i) begin
      pc_d = pc_q;
    end else if (pred_taken_i) begin
      pc_d = pred_target_i;  // target is taken as is, misalignment traps later
    end else begin
      pc_d = pc_seq;
    end
  end

  // Reset points one word below the first fetch so that the stage register
  // sees a slot it can recognize and squash.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= PC_PRE_RESET;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: rtl/bpu_bus.sv
`default_nettype none

interface bpu_bus
  import fetch_pkg::*;
();

  logic               taken;      // branch or jal predicted taken
  logic               pdt_res;    // direction from the selected predictor
  logic               which_pdt;  // bimodal or gshare
  logic [HIS_LEN-1:0] history;    // history used for this prediction

  // predictor side
  modport pred (
    output taken,
    output pdt_res,
    output which_pdt,
    output history
  );

  // stage register side
  modport stage (
    input taken,
    input pdt_res,
    input which_pdt,
    input history
  );

endinterface

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // *********************************************************************
  // datapath widths
  // *********************************************************************
  localparam int unsigned INST_LEN = 32;  // instruction and address width
  localparam int unsigned HIS_LEN  = 6;   // global history bits
  localparam int unsigned PHT_IDX  = 6;   // counter table index width
  localparam int unsigned PHT_SIZE = 2 ** PHT_IDX;

  // *********************************************************************
  // trap field layout
  // *********************************************************************
  localparam int unsigned TRAP_LEN          = 2;
  localparam int unsigned TRAP_ADDR_MISALIGN = 0;  // fetch address not word aligned
  localparam int unsigned TRAP_ACCESS_FAULT  = 1;  // instruction memory reported an error

  // *********************************************************************
  // fetch addresses and cleared slot contents
  // *********************************************************************
  localparam logic [INST_LEN-1:0] PC_RESET_ADDR = 32'h8000_0000;
  localparam logic [INST_LEN-1:0] PC_PRE_RESET  = PC_RESET_ADDR - 32'd4;  // squashed slot
  localparam logic [INST_LEN-1:0] PC_STEP       = 32'd4;
  localparam logic [INST_LEN-1:0] INST_NOP      = 32'h0000_0013;  // addi x0, x0, 0

  // opcodes seen by pre-decode
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // which_pdt encoding
  localparam logic PDT_BIMODAL = 1'b0;
  localparam logic PDT_GSHARE  = 1'b1;

  // counters start weakly not-taken, chooser weakly on bimodal
  localparam logic [1:0] CNT_INIT = 2'b01;

endpackage

`default_nettype wire
